// File: axi_consts.svh
`ifndef AXI_CONSTS_SVH
`define AXI_CONSTS_SVH

// ============================================================
// Bus widths
// ============================================================

`define AXI_ID_BITS 4
`define AXI_ADDR_BITS 32
`define AXI_DATA_BITS 32
`define AXI_STRB_BITS 4 // One strobe per data byte
`define AXI_LEN_BITS 8
`define AXI_SIZE_BITS 3

// ============================================================
// Address map
// ============================================================

// The memory window starts here and covers 2**AXI_MEM_SPAN_BITS bytes
`define AXI_MEM_BASE 32'h0000_0000
`define AXI_MEM_SPAN_BITS 12 // 4 KB, so 1024 words of 32 bits

`endif

// File: axi_pkg.sv
package axi_pkg;

	typedef enum logic [1:0] {
		burst_fixed = 2'b00,
		burst_incr = 2'b01,
		burst_wrap = 2'b10 // Handled as INCR by both slaves
	} axi_burst_e;

	typedef enum logic [1:0] {
		resp_okay = 2'b00,
		resp_exokay = 2'b01,
		resp_slverr = 2'b10,
		resp_decerr = 2'b11
	} axi_resp_e;

	// Shared by the memory slave and the default slave
	typedef enum logic [1:0] {
		st_idle = 2'b00,
		st_read = 2'b01,
		st_write = 2'b10,
		st_resp = 2'b11
	} slave_state_e;

	typedef enum logic [1:0] {
		rt_idle = 2'b00,
		rt_read = 2'b01,
		rt_write = 2'b10
	} route_state_e;

endpackage

// File: axi_mem_slave.sv
`timescale 1ns/1ps
`include "axi_consts.svh"

module axi_mem_slave (
	input logic clk,
	input logic rst,
	input logic [`AXI_ID_BITS-1:0] ar_id,
	input logic [`AXI_ADDR_BITS-1:0] ar_addr,
	input logic [`AXI_LEN_BITS-1:0] ar_len,
	input logic [`AXI_SIZE_BITS-1:0] ar_size,
	input axi_pkg::axi_burst_e ar_burst,
	input logic ar_valid,
	output logic ar_ready,
	output logic [`AXI_ID_BITS-1:0] r_id,
	output logic [`AXI_DATA_BITS-1:0] r_data,
	output axi_pkg::axi_resp_e r_resp,
	output logic r_last,
	output logic r_valid,
	input logic r_ready,
	input logic [`AXI_ID_BITS-1:0] aw_id,
	input logic [`AXI_ADDR_BITS-1:0] aw_addr,
	input logic [`AXI_LEN_BITS-1:0] aw_len,
	input logic [`AXI_SIZE_BITS-1:0] aw_size,
	input axi_pkg::axi_burst_e aw_burst,
	input logic aw_valid,
	output logic aw_ready,
	input logic [`AXI_DATA_BITS-1:0] w_data,
	input logic [`AXI_STRB_BITS-1:0] w_strb,
	input logic w_last,
	input logic w_valid,
	output logic w_ready,
	output logic [`AXI_ID_BITS-1:0] b_id,
	output axi_pkg::axi_resp_e b_resp,
	output logic b_valid,
	input logic b_ready
);

	import axi_pkg::*;

	slave_state_e state;

	logic [`AXI_DATA_BITS-1:0] mem [0:(1 << (`AXI_MEM_SPAN_BITS - 2)) - 1];

	logic [`AXI_ID_BITS-1:0] txn_id; // Only one transaction is open, so one ID serves R and B
	logic [`AXI_MEM_SPAN_BITS-3:0] idx;
	logic [`AXI_MEM_SPAN_BITS-3:0] nxt_idx;
	logic [`AXI_LEN_BITS-1:0] cnt; // Beats left after the current one
	axi_burst_e burst;

	// ============================================================
	// Handshake outputs
	// ============================================================

	assign ar_ready = (state == st_idle);
	assign aw_ready = (state == st_idle);
	assign r_valid = (state == st_read);
	assign w_ready = (state == st_write);
	assign b_valid = (state == st_resp);

	assign r_id = txn_id;
	assign r_resp = resp_okay;
	assign r_last = (cnt == '0);
	assign b_id = txn_id;
	assign b_resp = resp_okay;

	// A fixed burst keeps hitting the same word
	assign nxt_idx = (burst == burst_fixed) ? idx : idx + 1'b1;

	// ============================================================
	// Control FSM
	// ============================================================

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (ar_valid && ar_ready)
						state <= st_read; // Read wins when both are offered
					else if (aw_valid && aw_ready)
						state <= st_write;
				end
				st_read: if (r_valid && r_ready && r_last) state <= st_idle;
				st_write: if (w_valid && w_ready && w_last) state <= st_resp;
				st_resp: if (b_valid && b_ready) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	// ============================================================
	// Array and burst bookkeeping
	// ============================================================

	always_ff @(posedge clk) begin
		if (ar_valid && ar_ready) begin
			txn_id <= ar_id;
			idx <= ar_addr[`AXI_MEM_SPAN_BITS-1:2];
			cnt <= ar_len;
			burst <= ar_burst;
			r_data <= mem[ar_addr[`AXI_MEM_SPAN_BITS-1:2]]; // First beat is ready next cycle
		end else if (aw_valid && aw_ready) begin
			txn_id <= aw_id;
			idx <= aw_addr[`AXI_MEM_SPAN_BITS-1:2];
			burst <= aw_burst;
		end else if (r_valid && r_ready) begin
			idx <= nxt_idx;
			cnt <= cnt - 1'b1;
			r_data <= mem[nxt_idx];
		end else if (w_valid && w_ready) begin
			idx <= nxt_idx;
			for (int i = 0; i < `AXI_STRB_BITS; i++) begin
				if (w_strb[i])
					mem[idx][8*i +: 8] <= w_data[8*i +: 8];
			end
		end
	end

endmodule

// File: axi_default_slave.sv
`timescale 1ns/1ps
`include "axi_consts.svh"

module axi_default_slave (
	input logic clk,
	input logic rst,
	input logic [`AXI_ID_BITS-1:0] ar_id,
	input logic [`AXI_ADDR_BITS-1:0] ar_addr,
	input logic [`AXI_LEN_BITS-1:0] ar_len,
	input logic [`AXI_SIZE_BITS-1:0] ar_size,
	input axi_pkg::axi_burst_e ar_burst,
	input logic ar_valid,
	output logic ar_ready,
	output logic [`AXI_ID_BITS-1:0] r_id,
	output logic [`AXI_DATA_BITS-1:0] r_data,
	output axi_pkg::axi_resp_e r_resp,
	output logic r_last,
	output logic r_valid,
	input logic r_ready,
	input logic [`AXI_ID_BITS-1:0] aw_id,
	input logic [`AXI_ADDR_BITS-1:0] aw_addr,
	input logic [`AXI_LEN_BITS-1:0] aw_len,
	input logic [`AXI_SIZE_BITS-1:0] aw_size,
	input axi_pkg::axi_burst_e aw_burst,
	input logic aw_valid,
	output logic aw_ready,
	input logic [`AXI_DATA_BITS-1:0] w_data,
	input logic [`AXI_STRB_BITS-1:0] w_strb,
	input logic w_last,
	input logic w_valid,
	output logic w_ready,
	output logic [`AXI_ID_BITS-1:0] b_id,
	output axi_pkg::axi_resp_e b_resp,
	output logic b_valid,
	input logic b_ready
);

	import axi_pkg::*;

	slave_state_e state;

	logic [`AXI_ID_BITS-1:0] rd_id;
	logic [`AXI_ID_BITS-1:0] wr_id;
	logic [`AXI_LEN_BITS-1:0] rd_cnt;

	assign ar_ready = (state == st_idle);
	assign aw_ready = (state == st_idle);
	assign r_valid = (state == st_read);
	assign w_ready = (state == st_write); // W beats are taken and dropped
	assign b_valid = (state == st_resp);

	// Every access here falls outside the map
	assign r_id = rd_id;
	assign r_data = '0;
	assign r_resp = resp_decerr;
	assign r_last = (rd_cnt == '0);
	assign b_id = wr_id;
	assign b_resp = resp_decerr;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (ar_valid && ar_ready)
						state <= st_read;
					else if (aw_valid && aw_ready)
						state <= st_write;
				end
				st_read: if (r_valid && r_ready && r_last) state <= st_idle;
				st_write: if (w_valid && w_ready && w_last) state <= st_resp;
				st_resp: if (b_valid && b_ready) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ar_valid && ar_ready) begin
			rd_id <= ar_id;
			rd_cnt <= ar_len; // ARLEN+1 beats in total
		end else if (r_valid && r_ready) begin
			rd_cnt <= rd_cnt - 1'b1;
		end
		if (aw_valid && aw_ready && !(ar_valid && ar_ready))
			wr_id <= aw_id;
	end

endmodule

// File: axi_addr_router.sv
`timescale 1ns/1ps
`include "axi_consts.svh"

module axi_addr_router (
	input logic clk,
	input logic rst,
	// Upstream master side
	input logic [`AXI_ID_BITS-1:0] ar_id,
	input logic [`AXI_ADDR_BITS-1:0] ar_addr,
	input logic [`AXI_LEN_BITS-1:0] ar_len,
	input logic [`AXI_SIZE_BITS-1:0] ar_size,
	input axi_pkg::axi_burst_e ar_burst,
	input logic ar_valid,
	output logic ar_ready,
	output logic [`AXI_ID_BITS-1:0] r_id,
	output logic [`AXI_DATA_BITS-1:0] r_data,
	output axi_pkg::axi_resp_e r_resp,
	output logic r_last,
	output logic r_valid,
	input logic r_ready,
	input logic [`AXI_ID_BITS-1:0] aw_id,
	input logic [`AXI_ADDR_BITS-1:0] aw_addr,
	input logic [`AXI_LEN_BITS-1:0] aw_len,
	input logic [`AXI_SIZE_BITS-1:0] aw_size,
	input axi_pkg::axi_burst_e aw_burst,
	input logic aw_valid,
	output logic aw_ready,
	input logic [`AXI_DATA_BITS-1:0] w_data,
	input logic [`AXI_STRB_BITS-1:0] w_strb,
	input logic w_last,
	input logic w_valid,
	output logic w_ready,
	output logic [`AXI_ID_BITS-1:0] b_id,
	output axi_pkg::axi_resp_e b_resp,
	output logic b_valid,
	input logic b_ready,
	// Toward the memory slave and the default slave
	output logic [`AXI_ID_BITS-1:0] mem_ar_id, dft_ar_id, mem_aw_id, dft_aw_id,
	output logic [`AXI_ADDR_BITS-1:0] mem_ar_addr, dft_ar_addr, mem_aw_addr, dft_aw_addr,
	output logic [`AXI_LEN_BITS-1:0] mem_ar_len, dft_ar_len, mem_aw_len, dft_aw_len,
	output logic [`AXI_SIZE_BITS-1:0] mem_ar_size, dft_ar_size, mem_aw_size, dft_aw_size,
	output axi_pkg::axi_burst_e mem_ar_burst, dft_ar_burst, mem_aw_burst, dft_aw_burst,
	output logic mem_ar_valid, dft_ar_valid, mem_aw_valid, dft_aw_valid,
	input logic mem_ar_ready, dft_ar_ready, mem_aw_ready, dft_aw_ready,
	output logic [`AXI_DATA_BITS-1:0] mem_w_data, dft_w_data,
	output logic [`AXI_STRB_BITS-1:0] mem_w_strb, dft_w_strb,
	output logic mem_w_last, dft_w_last, mem_w_valid, dft_w_valid,
	input logic mem_w_ready, dft_w_ready,
	input logic [`AXI_ID_BITS-1:0] mem_r_id, dft_r_id, mem_b_id, dft_b_id,
	input logic [`AXI_DATA_BITS-1:0] mem_r_data, dft_r_data,
	input axi_pkg::axi_resp_e mem_r_resp, dft_r_resp, mem_b_resp, dft_b_resp,
	input logic mem_r_last, dft_r_last, mem_r_valid, dft_r_valid, mem_b_valid, dft_b_valid,
	output logic mem_r_ready, dft_r_ready, mem_b_ready, dft_b_ready
);

	import axi_pkg::*;

	route_state_e state;
	logic tgt_mem; // Set when the open transaction goes to the memory slave
	logic ar_hit, aw_hit;
	logic idle, aw_fwd;

	// ============================================================
	// Address decode and request steering
	// ============================================================

	assign ar_hit = ((ar_addr ^ `AXI_MEM_BASE) >> `AXI_MEM_SPAN_BITS) == '0;
	assign aw_hit = ((aw_addr ^ `AXI_MEM_BASE) >> `AXI_MEM_SPAN_BITS) == '0;

	assign idle = (state == rt_idle);
	assign aw_fwd = idle && !ar_valid; // A pending read holds the write back

	assign mem_ar_valid = idle && ar_valid && ar_hit;
	assign dft_ar_valid = idle && ar_valid && !ar_hit;
	assign ar_ready = idle && (ar_hit ? mem_ar_ready : dft_ar_ready);
	assign mem_aw_valid = aw_fwd && aw_valid && aw_hit;
	assign dft_aw_valid = aw_fwd && aw_valid && !aw_hit;
	assign aw_ready = aw_fwd && (aw_hit ? mem_aw_ready : dft_aw_ready);

	// Payload fans out to both, only the valid selects the slave
	assign {mem_ar_id, dft_ar_id} = {2{ar_id}};
	assign {mem_ar_addr, dft_ar_addr} = {2{ar_addr}};
	assign {mem_ar_len, dft_ar_len} = {2{ar_len}};
	assign {mem_ar_size, dft_ar_size} = {2{ar_size}};
	assign mem_ar_burst = ar_burst;
	assign dft_ar_burst = ar_burst;
	assign {mem_aw_id, dft_aw_id} = {2{aw_id}};
	assign {mem_aw_addr, dft_aw_addr} = {2{aw_addr}};
	assign {mem_aw_len, dft_aw_len} = {2{aw_len}};
	assign {mem_aw_size, dft_aw_size} = {2{aw_size}};
	assign mem_aw_burst = aw_burst;
	assign dft_aw_burst = aw_burst;
	assign {mem_w_data, dft_w_data} = {2{w_data}};
	assign {mem_w_strb, dft_w_strb} = {2{w_strb}};
	assign {mem_w_last, dft_w_last} = {2{w_last}};

	// ============================================================
	// Data and response channels
	// ============================================================

	assign mem_w_valid = (state == rt_write) && tgt_mem && w_valid;
	assign dft_w_valid = (state == rt_write) && !tgt_mem && w_valid;
	assign w_ready = (state == rt_write) && (tgt_mem ? mem_w_ready : dft_w_ready);

	assign mem_r_ready = (state == rt_read) && tgt_mem && r_ready;
	assign dft_r_ready = (state == rt_read) && !tgt_mem && r_ready;
	assign r_valid = (state == rt_read) && (tgt_mem ? mem_r_valid : dft_r_valid);
	assign r_id = tgt_mem ? mem_r_id : dft_r_id;
	assign r_data = tgt_mem ? mem_r_data : dft_r_data;
	assign r_resp = tgt_mem ? mem_r_resp : dft_r_resp;
	assign r_last = tgt_mem ? mem_r_last : dft_r_last;

	assign mem_b_ready = (state == rt_write) && tgt_mem && b_ready;
	assign dft_b_ready = (state == rt_write) && !tgt_mem && b_ready;
	assign b_valid = (state == rt_write) && (tgt_mem ? mem_b_valid : dft_b_valid);
	assign b_id = tgt_mem ? mem_b_id : dft_b_id;
	assign b_resp = tgt_mem ? mem_b_resp : dft_b_resp;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= rt_idle;
			tgt_mem <= 1'b0;
		end else begin
			case (state)
				rt_idle: begin
					if (ar_valid && ar_ready) begin
						state <= rt_read;
						tgt_mem <= ar_hit;
					end else if (aw_valid && aw_ready) begin
						state <= rt_write;
						tgt_mem <= aw_hit;
					end
				end
				rt_read: if (r_valid && r_ready && r_last) state <= rt_idle;
				rt_write: if (b_valid && b_ready) state <= rt_idle;
				default: state <= rt_idle;
			endcase
		end
	end

endmodule

// File: axi_sub_top.sv
`timescale 1ns/1ps
`include "axi_consts.svh"

module axi_sub_top (
	input logic clk,
	input logic rst,
	input logic [`AXI_ID_BITS-1:0] ar_id,
	input logic [`AXI_ADDR_BITS-1:0] ar_addr,
	input logic [`AXI_LEN_BITS-1:0] ar_len,
	input logic [`AXI_SIZE_BITS-1:0] ar_size,
	input axi_pkg::axi_burst_e ar_burst,
	input logic ar_valid,
	output logic ar_ready,
	output logic [`AXI_ID_BITS-1:0] r_id,
	output logic [`AXI_DATA_BITS-1:0] r_data,
	output axi_pkg::axi_resp_e r_resp,
	output logic r_last,
	output logic r_valid,
	input logic r_ready,
	input logic [`AXI_ID_BITS-1:0] aw_id,
	input logic [`AXI_ADDR_BITS-1:0] aw_addr,
	input logic [`AXI_LEN_BITS-1:0] aw_len,
	input logic [`AXI_SIZE_BITS-1:0] aw_size,
	input axi_pkg::axi_burst_e aw_burst,
	input logic aw_valid,
	output logic aw_ready,
	input logic [`AXI_DATA_BITS-1:0] w_data,
	input logic [`AXI_STRB_BITS-1:0] w_strb,
	input logic w_last,
	input logic w_valid,
	output logic w_ready,
	output logic [`AXI_ID_BITS-1:0] b_id,
	output axi_pkg::axi_resp_e b_resp,
	output logic b_valid,
	input logic b_ready
);

	import axi_pkg::*;

	logic [`AXI_ID_BITS-1:0] mem_ar_id, mem_r_id, mem_aw_id, mem_b_id;
	logic [`AXI_ID_BITS-1:0] dft_ar_id, dft_r_id, dft_aw_id, dft_b_id;
	logic [`AXI_ADDR_BITS-1:0] mem_ar_addr, mem_aw_addr, dft_ar_addr, dft_aw_addr;
	logic [`AXI_LEN_BITS-1:0] mem_ar_len, mem_aw_len, dft_ar_len, dft_aw_len;
	logic [`AXI_SIZE_BITS-1:0] mem_ar_size, mem_aw_size, dft_ar_size, dft_aw_size;
	axi_burst_e mem_ar_burst, mem_aw_burst, dft_ar_burst, dft_aw_burst;
	logic [`AXI_DATA_BITS-1:0] mem_r_data, mem_w_data, dft_r_data, dft_w_data;
	logic [`AXI_STRB_BITS-1:0] mem_w_strb, dft_w_strb;
	axi_resp_e mem_r_resp, mem_b_resp, dft_r_resp, dft_b_resp;
	logic mem_ar_valid, mem_ar_ready, mem_r_last, mem_r_valid, mem_r_ready, mem_aw_valid;
	logic mem_aw_ready, mem_w_last, mem_w_valid, mem_w_ready, mem_b_valid, mem_b_ready;
	logic dft_ar_valid, dft_ar_ready, dft_r_last, dft_r_valid, dft_r_ready, dft_aw_valid;
	logic dft_aw_ready, dft_w_last, dft_w_valid, dft_w_ready, dft_b_valid, dft_b_ready;

	// Router port names match the top's ports and wires one for one
	axi_addr_router u_router (.*);

	axi_mem_slave u_mem (
		.clk, .rst,
		.ar_id(mem_ar_id), .ar_addr(mem_ar_addr), .ar_len(mem_ar_len), .ar_size(mem_ar_size),
		.ar_burst(mem_ar_burst), .ar_valid(mem_ar_valid), .ar_ready(mem_ar_ready),
		.r_id(mem_r_id), .r_data(mem_r_data), .r_resp(mem_r_resp), .r_last(mem_r_last),
		.r_valid(mem_r_valid), .r_ready(mem_r_ready),
		.aw_id(mem_aw_id), .aw_addr(mem_aw_addr), .aw_len(mem_aw_len), .aw_size(mem_aw_size),
		.aw_burst(mem_aw_burst), .aw_valid(mem_aw_valid), .aw_ready(mem_aw_ready),
		.w_data(mem_w_data), .w_strb(mem_w_strb), .w_last(mem_w_last),
		.w_valid(mem_w_valid), .w_ready(mem_w_ready),
		.b_id(mem_b_id), .b_resp(mem_b_resp), .b_valid(mem_b_valid), .b_ready(mem_b_ready)
	);

	axi_default_slave u_dft (
		.clk, .rst,
		.ar_id(dft_ar_id), .ar_addr(dft_ar_addr), .ar_len(dft_ar_len), .ar_size(dft_ar_size),
		.ar_burst(dft_ar_burst), .ar_valid(dft_ar_valid), .ar_ready(dft_ar_ready),
		.r_id(dft_r_id), .r_data(dft_r_data), .r_resp(dft_r_resp), .r_last(dft_r_last),
		.r_valid(dft_r_valid), .r_ready(dft_r_ready),
		.aw_id(dft_aw_id), .aw_addr(dft_aw_addr), .aw_len(dft_aw_len), .aw_size(dft_aw_size),
		.aw_burst(dft_aw_burst), .aw_valid(dft_aw_valid), .aw_ready(dft_aw_ready),
		.w_data(dft_w_data), .w_strb(dft_w_strb), .w_last(dft_w_last),
		.w_valid(dft_w_valid), .w_ready(dft_w_ready),
		.b_id(dft_b_id), .b_resp(dft_b_resp), .b_valid(dft_b_valid), .b_ready(dft_b_ready)
	);

endmodule

// File: tb_axi_checker.sv
`timescale 1ns/1ps
`include "axi_consts.svh"

module tb_axi_checker (
	input logic clk,
	input logic rst,
	input logic [`AXI_ID_BITS-1:0] ar_id, r_id, aw_id, b_id,
	input logic [`AXI_ADDR_BITS-1:0] ar_addr, aw_addr,
	input logic [`AXI_LEN_BITS-1:0] ar_len, aw_len,
	input logic [`AXI_SIZE_BITS-1:0] ar_size, aw_size,
	input axi_pkg::axi_burst_e ar_burst, aw_burst,
	input logic [`AXI_DATA_BITS-1:0] r_data, w_data,
	input logic [`AXI_STRB_BITS-1:0] w_strb,
	input axi_pkg::axi_resp_e r_resp, b_resp,
	input logic ar_valid, ar_ready, r_last, r_valid, r_ready, aw_valid, aw_ready,
	input logic w_last, w_valid, w_ready, b_valid, b_ready,
	output int err_count
);

	import axi_pkg::*;

	logic [`AXI_DATA_BITS-1:0] ref_mem [0:(1 << (`AXI_MEM_SPAN_BITS - 2)) - 1];

	logic rd_open, rd_map, rd_fixed, wr_open, wr_map, wr_fixed;
	logic [`AXI_MEM_SPAN_BITS-3:0] rd_idx, wr_idx;
	logic [`AXI_ID_BITS-1:0] rd_id, wr_id, r_id_q, b_id_q;
	int rd_len, rd_beat, wr_len, wr_beats;
	int rst_cycles;
	logic released, r_hold, b_hold, r_last_q;
	logic r_due, b_due;
	logic [`AXI_DATA_BITS-1:0] r_data_q;
	axi_resp_e r_resp_q, b_resp_q;

	initial begin
		err_count = 0;
		rst_cycles = 0;
		released = 1'b0;
		rd_open = 1'b0;
		wr_open = 1'b0;
		r_hold = 1'b0;
		b_hold = 1'b0;
		r_due = 1'b0;
		b_due = 1'b0;
	end

	task automatic compare_value(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		if (act !== exp) begin
			$display("ERROR %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
			err_count++;
		end
	endtask

	task automatic report_failure(input string msg);
		$display("%s at %0t", msg, $time);
		err_count++;
	endtask

	// The window runs from the base over 2**span bytes
	function automatic bit in_window(input logic [`AXI_ADDR_BITS-1:0] addr);
		in_window = (addr >= `AXI_MEM_BASE) &&
			(addr - `AXI_MEM_BASE < (33'd1 << `AXI_MEM_SPAN_BITS));
	endfunction

	function automatic logic [`AXI_DATA_BITS-1:0] merge_bytes(
			input logic [`AXI_DATA_BITS-1:0] old, input logic [`AXI_DATA_BITS-1:0] data,
			input logic [`AXI_STRB_BITS-1:0] strb);
		logic [`AXI_DATA_BITS-1:0] res;
		res = old;
		for (int b = 0; b < `AXI_STRB_BITS; b++) begin
			if (strb[b])
				res[8*b +: 8] = data[8*b +: 8];
		end
		merge_bytes = res;
	endfunction

	task automatic expect_quiet();
		compare_value("r_valid", 0, r_valid);
		compare_value("b_valid", 0, b_valid);
		compare_value("w_ready", 0, w_ready);
	endtask

	// ============================================================
	// Per-cycle tracking after reset
	// ============================================================

	task automatic track_cycle();
		if (r_hold) begin // A stalled beat must not move
			compare_value("r_valid", 1, r_valid);
			compare_value("r_id", r_id_q, r_id);
			compare_value("r_data", r_data_q, r_data);
			compare_value("r_resp", r_resp_q, r_resp);
			compare_value("r_last", r_last_q, r_last);
		end
		if (b_hold) begin
			compare_value("b_valid", 1, b_valid);
			compare_value("b_id", b_id_q, b_id);
			compare_value("b_resp", b_resp_q, b_resp);
		end
		r_hold = r_valid && !r_ready;
		b_hold = b_valid && !b_ready;
		r_id_q = r_id;
		r_data_q = r_data;
		r_resp_q = r_resp;
		r_last_q = r_last;
		b_id_q = b_id;
		b_resp_q = b_resp;

		if (r_due) // First read data follows the AR handshake by one cycle
			compare_value("r_valid", 1, r_valid);
		if (b_due)
			compare_value("b_valid", 1, b_valid);
		r_due = ar_valid && ar_ready;
		b_due = w_valid && w_ready && w_last;

		if (rd_open || ar_valid)
			compare_value("aw_ready", 0, aw_ready); // Reads go first

		if (r_valid && r_ready) begin
			if (!rd_open) begin
				report_failure("An R beat arrived while no read was open");
			end else begin
				compare_value("r_data", rd_map ? ref_mem[rd_idx] : '0, r_data);
				compare_value("r_resp", rd_map ? resp_okay : resp_decerr, r_resp);
				compare_value("r_id", rd_id, r_id);
				compare_value("r_last", rd_beat == rd_len, r_last);
				rd_open = (rd_beat != rd_len);
				rd_beat++;
				if (!rd_fixed)
					rd_idx++;
			end
		end

		if (w_valid && w_ready) begin
			if (!wr_open) begin
				report_failure("A W beat was taken while no write was open");
			end else begin
				if (wr_map)
					ref_mem[wr_idx] = merge_bytes(ref_mem[wr_idx], w_data, w_strb);
				wr_beats++;
				if (!wr_fixed)
					wr_idx++;
			end
		end

		if (b_valid && b_ready) begin
			if (!wr_open) begin
				report_failure("A write response arrived while no write was open");
			end else begin
				compare_value("b_resp", wr_map ? resp_okay : resp_decerr, b_resp);
				compare_value("b_id", wr_id, b_id);
				compare_value("w beat count", wr_len + 1, wr_beats);
				wr_open = 1'b0;
			end
		end

		if (ar_valid && ar_ready) begin
			rd_open = 1'b1;
			rd_map = in_window(ar_addr);
			rd_fixed = (ar_burst == burst_fixed);
			rd_idx = ar_addr[`AXI_MEM_SPAN_BITS-1:2];
			rd_id = ar_id;
			rd_len = ar_len;
			rd_beat = 0;
		end
		if (aw_valid && aw_ready) begin
			wr_open = 1'b1;
			wr_map = in_window(aw_addr);
			wr_fixed = (aw_burst == burst_fixed);
			wr_idx = aw_addr[`AXI_MEM_SPAN_BITS-1:2];
			wr_id = aw_id;
			wr_len = aw_len;
			wr_beats = 0;
		end
	endtask

	always @(posedge clk) begin
		if (!rst) begin
			if (rst_cycles > 0) // The first edge is where the flops settle
				expect_quiet();
			rst_cycles++;
		end else if (!released) begin
			expect_quiet();
			compare_value("ar_ready", 1, ar_ready);
			compare_value("aw_ready", 1, aw_ready);
			released = 1'b1;
		end else begin
			track_cycle();
		end
	end

endmodule

// File: tb_axi_sub.sv
`timescale 1ns/1ps
`include "axi_consts.svh"

module tb_axi_sub;

	import axi_pkg::*;

	localparam int KIND_RD = 0;
	localparam int KIND_WR = 1;
	localparam int KIND_RW = 2; // AR and AW raised in the same cycle
	localparam int EV_AR = 0;
	localparam int EV_AW = 1;
	localparam int EV_W = 2;
	localparam int EV_R = 3;
	localparam int EV_B = 4;
	localparam int LIMIT = 100; // Cycles allowed for any single wait

	typedef struct packed {
		logic [1:0] kind;
		logic [`AXI_ID_BITS-1:0] id;
		logic [`AXI_ADDR_BITS-1:0] addr;
		logic [`AXI_LEN_BITS-1:0] len;
		axi_burst_e burst;
		logic [`AXI_STRB_BITS-1:0] strb;
	} txn_t;

	logic clk;
	logic rst;
	logic [`AXI_ID_BITS-1:0] ar_id, r_id, aw_id, b_id;
	logic [`AXI_ADDR_BITS-1:0] ar_addr, aw_addr;
	logic [`AXI_LEN_BITS-1:0] ar_len, aw_len;
	logic [`AXI_SIZE_BITS-1:0] ar_size, aw_size;
	axi_burst_e ar_burst, aw_burst;
	logic [`AXI_DATA_BITS-1:0] r_data, w_data;
	logic [`AXI_STRB_BITS-1:0] w_strb;
	axi_resp_e r_resp, b_resp;
	logic ar_valid, ar_ready, r_last, r_valid, r_ready, aw_valid, aw_ready;
	logic w_last, w_valid, w_ready, b_valid, b_ready;

	int seed = 66498;
	int timeouts = 0;
	int err_count;
	txn_t txns[$];
	logic [`AXI_DATA_BITS-1:0] wr_words[$]; // Write data in beat order over the whole table

	axi_sub_top u_axi_sub_top (.*);

	tb_axi_checker u_checker (.*);

	always #20 clk = ~clk;

	// Random back-pressure on both response channels
	always @(posedge clk) begin
		if (rst) begin
			r_ready <= ($random(seed) & 3) != 0;
			b_ready <= ($random(seed) & 1) != 0;
		end
	end

	function automatic bit seen(input int ev);
		case (ev)
			EV_AR: seen = ar_ready;
			EV_AW: seen = aw_ready;
			EV_W: seen = w_ready;
			EV_R: seen = r_valid && r_ready && r_last;
			default: seen = b_valid && b_ready;
		endcase
	endfunction

	task automatic wait_for(input int ev, input string what);
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!seen(ev) && n < LIMIT);
		if (!seen(ev)) begin
			$display("Timed out after %0d cycles waiting for %s", LIMIT, what);
			timeouts++;
		end
	endtask

	task automatic add_txn(input int kind, input logic [`AXI_ID_BITS-1:0] id,
			input logic [`AXI_ADDR_BITS-1:0] addr, input logic [`AXI_LEN_BITS-1:0] len,
			input axi_burst_e burst, input logic [`AXI_STRB_BITS-1:0] strb);
		txn_t t;
		t.kind = kind;
		t.id = id;
		t.addr = addr;
		t.len = len;
		t.burst = burst;
		t.strb = strb;
		txns.push_back(t);
		if (kind != KIND_RD) begin
			for (int i = 0; i <= len; i++)
				wr_words.push_back($random(seed));
		end
	endtask

	task automatic send_w_beats(input txn_t t);
		for (int i = 0; i <= t.len; i++) begin
			w_data <= wr_words.pop_front();
			w_strb <= t.strb;
			w_last <= (i == t.len);
			w_valid <= 1'b1;
			wait_for(EV_W, "w_ready");
		end
		w_valid <= 1'b0;
		w_last <= 1'b0;
		wait_for(EV_B, "the write response");
	endtask

	initial begin
		txn_t t;
		clk = 1'b0;
		rst = 1'b0;
		{ar_id, ar_addr, ar_len, ar_valid, aw_id, aw_addr, aw_len, aw_valid} = '0;
		ar_size = 3'd2;
		aw_size = 3'd2;
		ar_burst = burst_incr;
		aw_burst = burst_incr;
		{w_data, w_strb, w_last, w_valid, r_ready, b_ready} = '0;

		// ============================================================
		// Transaction table: kind, id, address, len, burst, strobes
		// ============================================================
		add_txn(KIND_WR, 4'h1, 32'h0000_0000, 8'd3, burst_incr, 4'hf);
		add_txn(KIND_WR, 4'h2, 32'h0000_0010, 8'd0, burst_incr, 4'hf);
		add_txn(KIND_WR, 4'h3, 32'h0000_0010, 8'd2, burst_fixed, 4'h5);
		add_txn(KIND_WR, 4'h4, 32'h0000_0004, 8'd1, burst_incr, 4'ha);
		add_txn(KIND_RD, 4'h5, 32'h0000_0000, 8'd3, burst_incr, 4'h0);
		add_txn(KIND_RD, 4'h6, 32'h0000_0010, 8'd1, burst_fixed, 4'h0);
		add_txn(KIND_RD, 4'h7, 32'h0000_2000, 8'd4, burst_incr, 4'h0); // Unmapped
		add_txn(KIND_WR, 4'h8, 32'h8000_0000, 8'd2, burst_incr, 4'hf); // Unmapped
		add_txn(KIND_RD, 4'h9, 32'h0000_0000, 8'd4, burst_incr, 4'h0);
		add_txn(KIND_RW, 4'ha, 32'h0000_0008, 8'd1, burst_incr, 4'h3);
		add_txn(KIND_RD, 4'hb, 32'h0000_0008, 8'd1, burst_incr, 4'h0);
		add_txn(KIND_RD, 4'hc, 32'h0000_1000, 8'd0, burst_incr, 4'h0); // First byte past the window

		repeat (16) @(posedge clk);
		rst <= 1'b1;
		repeat (2) @(posedge clk);

		for (int k = 0; k < txns.size(); k++) begin
			t = txns[k];
			if (t.kind != KIND_WR) begin
				ar_id <= t.id;
				ar_addr <= t.addr;
				ar_len <= t.len;
				ar_burst <= t.burst;
				ar_valid <= 1'b1;
			end
			if (t.kind != KIND_RD) begin
				aw_id <= t.id;
				aw_addr <= t.addr;
				aw_len <= t.len;
				aw_burst <= t.burst;
				aw_valid <= 1'b1;
			end
			if (t.kind != KIND_WR) begin
				wait_for(EV_AR, "ar_ready");
				ar_valid <= 1'b0;
				wait_for(EV_R, "the last read beat");
			end
			if (t.kind != KIND_RD) begin
				wait_for(EV_AW, "aw_ready"); // A write raised with a read stays pending here
				aw_valid <= 1'b0;
				send_w_beats(t);
			end
		end

		repeat (4) @(posedge clk);
		@(negedge clk);
		$display("Error counts: checks %0d, timeouts %0d", err_count, timeouts);
		if (err_count == 0 && timeouts == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: src.f
+incdir+.
axi_pkg.sv
axi_mem_slave.sv
axi_default_slave.sv
axi_addr_router.sv
axi_sub_top.sv
tb_axi_checker.sv
tb_axi_sub.sv

// File: Bender.yml
package:
  name: axi_sub

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - axi_pkg.sv
      - axi_mem_slave.sv
      - axi_default_slave.sv
      - axi_addr_router.sv
      - axi_sub_top.sv
      - target: test
        files:
          - tb_axi_checker.sv
          - tb_axi_sub.sv
